//--- rq_pkg.sv
`default_nettype none

// Requester side of the shared memory read path
package rq_pkg;

    // Number of read controllers sharing the memory
    localparam int NUM_RQ = 2;

    // Width of a requester id
    localparam int RQ_ID_W = 1;

    // Requester ids that double as the read tag on the memory side
    typedef enum logic [RQ_ID_W-1:0] {
        RQ_SCAN = 1'b0,
        RQ_HOST = 1'b1
    } rq_id_e;

endpackage : rq_pkg

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

// Memory read bus and write port definitions
package mem_pkg;
    import rq_pkg::*;

    // Memory geometry
    localparam int ADDR_W    = 8;
    localparam int DATA_W    = 32;
    localparam int MEM_DEPTH = 256;

    // One controller's read request
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } mem_rd_req_t;

    // One controller's read response
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] data;
    } mem_rd_resp_t;

    // Request as seen by the memory with the owner's id as tag
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        rq_id_e            id;
    } mem_tag_req_t;

    // Memory response returned with the tag of the read
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] data;
        rq_id_e            id;
    } mem_tag_resp_t;

    // Write port
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

endpackage : mem_pkg

`default_nettype wire

//--- mem_rd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_arbiter
    import rq_pkg::*, mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_rd_req_t rd_req [NUM_RQ],
    input  logic        mem_rdy,
    output rq_id_e      grant
);

    // Round-robin pointer marking the first requester looked at in the search
    rq_id_e ptr;

    // Granted request taken by the memory this cycle
    logic accept;

    // Id that follows a given one and wraps at NUM_RQ
    function automatic rq_id_e next_id(input rq_id_e id);
        int unsigned nxt;
        nxt = (int'(id) + 1) % NUM_RQ;
        return rq_id_e'(nxt[RQ_ID_W-1:0]);
    endfunction

    // Search from the pointer for the first pending requester
    // With nothing pending the grant rests on the pointer
    always_comb begin
        int unsigned idx;
        logic        found;
        grant = ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_RQ; i++) begin
            idx = (int'(ptr) + i) % NUM_RQ;
            if (!found && rd_req[idx].req) begin
                grant = rq_id_e'(idx[RQ_ID_W-1:0]);
                found = 1'b1;
            end
        end
    end

    assign accept = rd_req[grant].req && mem_rdy;

    // Pointer moves past the owner once its read is taken,
    // so two busy requesters alternate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= RQ_SCAN;
        end else if (accept) begin
            ptr <= next_id(grant);
        end
    end

endmodule : mem_rd_arbiter

`default_nettype wire

//--- mem_rd_mux.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_mux
    import rq_pkg::*, mem_pkg::*;
(
    input  mem_rd_req_t   rd_req  [NUM_RQ],
    input  rq_id_e        grant,
    input  logic          mem_rdy,
    input  mem_tag_resp_t tag_resp,
    output mem_tag_req_t  tag_req,
    output logic          rdy     [NUM_RQ],
    output mem_rd_resp_t  rd_resp [NUM_RQ]
);

    // Request path follows the grant, which also becomes the tag
    always_comb begin
        tag_req.req  = rd_req[grant].req;
        tag_req.addr = rd_req[grant].addr;
        tag_req.id   = grant;
    end

    for (genvar g = 0; g < NUM_RQ; g++) begin : g_rq
        logic is_owner;
        logic is_dest;

        // Ready goes to the current owner only
        assign is_owner = (int'(grant) == g);

        // Responses follow their tag, not the current grant,
        // since the owner may have changed while the read was in flight
        assign is_dest = (int'(tag_resp.id) == g);

        assign rdy[g] = mem_rdy && is_owner;

        always_comb begin
            if (tag_resp.ack && is_dest) begin
                rd_resp[g].ack  = 1'b1;
                rd_resp[g].data = tag_resp.data;
            end else begin
                rd_resp[g].ack  = 1'b0;
                rd_resp[g].data = '0;
            end
        end
    end : g_rq

endmodule : mem_rd_mux

`default_nettype wire

//--- mem_rd_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_ram
    import rq_pkg::*, mem_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  mem_tag_req_t  tag_req,
    input  mem_wr_t       wr,
    output logic          mem_rdy,
    output mem_tag_resp_t tag_resp
);

    // Storage
    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // A read is taken whenever the memory is ready
    logic accept;

    // Stage one
    logic              s1_vld;
    rq_id_e            s1_id;
    logic [DATA_W-1:0] s1_data;

    // Stage two drives the response
    logic              s2_ack;
    rq_id_e            s2_id;
    logic [DATA_W-1:0] s2_data;

    assign accept = tag_req.req && mem_rdy;

    // Ready from the first edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rdy <= 1'b0;
        end else begin
            mem_rdy <= 1'b1;
        end
    end

    // Write port and array read share the edge
    // A read of the address being written sees the old word
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        if (accept) begin
            s1_data <= mem[tag_req.addr];
            s1_id   <= tag_req.id;
        end
    end

    // Valid bits of both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            s2_ack <= 1'b0;
        end else begin
            s1_vld <= accept;
            s2_ack <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld) begin
            s2_data <= s1_data;
            s2_id   <= s1_id;
        end
    end

    always_comb begin
        tag_resp.ack  = s2_ack;
        tag_resp.data = s2_data;
        tag_resp.id   = s2_id;
    end

endmodule : mem_rd_ram

`default_nettype wire

//--- mem_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rd_top
    import rq_pkg::*, mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  mem_rd_req_t  rd_req  [NUM_RQ],
    input  mem_wr_t      wr,
    output logic         rdy     [NUM_RQ],
    output mem_rd_resp_t rd_resp [NUM_RQ]
);

    // Owner of the read bus this cycle
    rq_id_e grant;

    // Memory side of the mux
    mem_tag_req_t  tag_req;
    mem_tag_resp_t tag_resp;
    logic          mem_rdy;

    mem_rd_arbiter mem_rd_arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_req  (rd_req),
        .mem_rdy (mem_rdy),
        .grant   (grant)
    );

    mem_rd_mux mem_rd_mux_i (
        .rd_req   (rd_req),
        .grant    (grant),
        .mem_rdy  (mem_rdy),
        .tag_resp (tag_resp),
        .tag_req  (tag_req),
        .rdy      (rdy),
        .rd_resp  (rd_resp)
    );

    mem_rd_ram mem_rd_ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tag_req  (tag_req),
        .wr       (wr),
        .mem_rdy  (mem_rdy),
        .tag_resp (tag_resp)
    );

endmodule : mem_rd_top

`default_nettype wire

//--- tb_mem_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_rd_top
    import rq_pkg::*, mem_pkg::*;
();

    localparam int          TIMEOUT = 50;
    localparam logic [31:0] SEED    = 32'hdd37_0fb5;
    localparam int          N_STEPS = 10;

    typedef enum logic [1:0] {
        ST_WRITE,
        ST_READ,
        ST_READ_WRITE
    } step_kind_e;

    // One row of the stimulus table with addr indexed by requester id
    typedef struct packed {
        step_kind_e                    kind;
        logic [NUM_RQ-1:0]             mask;
        logic [NUM_RQ-1:0][ADDR_W-1:0] addr;
        int                            len;
    } step_t;

    // Expected response with due as the cycle count at which ack is sampled
    typedef struct packed {
        rq_id_e            id;
        logic [DATA_W-1:0] data;
        int                due;
    } exp_t;

    logic         clk = 1'b0;
    logic         rst_n;
    mem_rd_req_t  rd_req  [NUM_RQ];
    mem_wr_t      wr;
    logic         rdy     [NUM_RQ];
    mem_rd_resp_t rd_resp [NUM_RQ];

    // Reference model state
    logic [DATA_W-1:0] model [MEM_DEPTH];
    exp_t              exp_q [$];
    rq_id_e            exp_ptr;
    logic              mem_up;
    logic              acc [NUM_RQ];
    int                cyc;
    step_t             steps [N_STEPS];

    always #50 clk = ~clk;

    mem_rd_top mem_rd_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_req  (rd_req),
        .wr      (wr),
        .rdy     (rdy),
        .rd_resp (rd_resp)
    );

    function automatic step_t mk_step(input step_kind_e kind, input logic [NUM_RQ-1:0] mask,
                                      input logic [ADDR_W-1:0] scan_addr,
                                      input logic [ADDR_W-1:0] host_addr, input int len);
        step_t s;
        s.kind          = kind;
        s.mask          = mask;
        s.addr[RQ_SCAN] = scan_addr;
        s.addr[RQ_HOST] = host_addr;
        s.len           = len;
        return s;
    endfunction

    task automatic check_resp(input int r, input mem_rd_resp_t exp, input mem_rd_resp_t act);
        if (act !== exp) begin
            $write("MISMATCH at %0t: rd_resp[%0d] expected ack=%0b data=%08h, ",
                   $time, r, exp.ack, exp.data);
            $display("got ack=%0b data=%08h", act.ack, act.data);
            $display("** FAIL **");
            $fatal(1, "response check failed");
        end
    endtask

    task automatic check_rdy(input int r, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: rdy[%0d] expected %0b, got %0b", $time, r, exp, act);
            $display("** FAIL **");
            $fatal(1, "ready check failed");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "wait timed out");
    endtask

    // Check at the falling edge and step past the rising edge
    task automatic tick();
        mem_rd_resp_t exp_resp;
        rq_id_e       exp_grant;
        logic         exp_r;
        int           cand;
        exp_t         ent;
        @(negedge clk);
        for (int r = 0; r < NUM_RQ; r++) begin
            exp_resp = '0;
            if (exp_q.size() > 0 && exp_q[0].due == cyc && int'(exp_q[0].id) == r) begin
                exp_resp.ack  = 1'b1;
                exp_resp.data = exp_q[0].data;
            end
            check_resp(r, exp_resp, rd_resp[r]);
        end
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            void'(exp_q.pop_front());
        end
        // First pending requester at or after the pointer owns the bus
        exp_grant = exp_ptr;
        for (int i = 0; i < NUM_RQ; i++) begin
            cand = (int'(exp_ptr) + i) % NUM_RQ;
            if (rd_req[cand].req) begin
                exp_grant = rq_id_e'(RQ_ID_W'(cand));
                break;
            end
        end
        for (int r = 0; r < NUM_RQ; r++) begin
            exp_r = mem_up && (int'(exp_grant) == r);
            check_rdy(r, exp_r, rdy[r]);
            acc[r] = rd_req[r].req && exp_r;
            if (acc[r]) begin
                // Data is read before a write on the same edge lands
                ent.id   = rq_id_e'(RQ_ID_W'(r));
                ent.data = model[rd_req[r].addr];
                ent.due  = cyc + 2;
                exp_q.push_back(ent);
                exp_ptr = rq_id_e'(RQ_ID_W'((r + 1) % NUM_RQ));
            end
        end
        if (wr.en) begin
            model[wr.addr] = wr.data;
        end
        @(posedge clk);
        cyc++;
        if (rst_n) begin
            mem_up = 1'b1;
        end
        #1;
    endtask

    task automatic run_write(input step_t s);
        for (int i = 0; i < s.len; i++) begin
            wr.en   = 1'b1;
            wr.addr = s.addr[RQ_SCAN] + ADDR_W'(i);
            wr.data = $urandom;
            tick();
        end
        wr = '0;
    endtask

    // Each masked requester reads len words from its start address
    task automatic run_read(input step_t s);
        int   cnt [NUM_RQ];
        int   guard;
        logic busy;
        for (int r = 0; r < NUM_RQ; r++) begin
            cnt[r]         = 0;
            rd_req[r].req  = s.mask[r];
            rd_req[r].addr = s.addr[r];
        end
        if (s.kind == ST_READ_WRITE) begin
            wr.en   = 1'b1;
            wr.addr = s.addr[RQ_SCAN];
            wr.data = $urandom;
        end
        guard = 0;
        busy  = |s.mask;
        while (busy) begin
            tick();
            wr   = '0;
            busy = 1'b0;
            for (int r = 0; r < NUM_RQ; r++) begin
                if (acc[r]) begin
                    cnt[r]++;
                    if (cnt[r] == s.len) begin
                        rd_req[r].req = 1'b0;
                    end else begin
                        rd_req[r].addr = rd_req[r].addr + ADDR_W'(1);
                    end
                end
                if (rd_req[r].req) begin
                    busy = 1'b1;
                end
            end
            guard++;
            if (guard > TIMEOUT) begin
                fail_timeout("read acceptance");
            end
        end
    endtask

    task automatic wait_idle();
        int guard;
        guard = 0;
        while (exp_q.size() > 0) begin
            tick();
            guard++;
            if (guard > TIMEOUT) begin
                fail_timeout("outstanding read responses");
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n   = 1'b0;
        wr      = '0;
        for (int r = 0; r < NUM_RQ; r++) begin
            rd_req[r] = '0;
            acc[r]    = 1'b0;
        end
        cyc     = 0;
        mem_up  = 1'b0;
        exp_ptr = RQ_SCAN;

        steps[0] = mk_step(ST_WRITE,      2'b00, 8'h10, 8'h00, 8);
        steps[1] = mk_step(ST_WRITE,      2'b00, 8'h40, 8'h00, 8);
        steps[2] = mk_step(ST_READ,       2'b01, 8'h12, 8'h00, 1);
        steps[3] = mk_step(ST_READ,       2'b10, 8'h00, 8'h14, 4);
        steps[4] = mk_step(ST_READ,       2'b11, 8'h10, 8'h40, 4);
        steps[5] = mk_step(ST_READ,       2'b11, 8'h44, 8'h16, 2);
        steps[6] = mk_step(ST_WRITE,      2'b00, 8'h12, 8'h00, 1);
        steps[7] = mk_step(ST_READ,       2'b01, 8'h12, 8'h00, 1);
        steps[8] = mk_step(ST_READ_WRITE, 2'b01, 8'h13, 8'h00, 1);
        steps[9] = mk_step(ST_READ,       2'b10, 8'h00, 8'h13, 1);

        // Align to the drive point after a rising edge
        @(posedge clk);
        #1;
        for (int i = 0; i < 5; i++) begin
            tick();
        end
        rst_n = 1'b1;
        // No edge has seen the release yet, so ready is still low here
        tick();

        for (int i = 0; i < N_STEPS; i++) begin
            if (steps[i].kind == ST_WRITE) begin
                run_write(steps[i]);
            end else begin
                run_read(steps[i]);
            end
            wait_idle();
        end
        tick();

        $display("** PASS **");
        $finish;
    end

endmodule : tb_mem_rd_top

`default_nettype wire

//--- list.f
rq_pkg.sv
mem_pkg.sv
mem_rd_arbiter.sv
mem_rd_mux.sv
mem_rd_ram.sv
mem_rd_top.sv
tb_mem_rd_top.sv

//--- Makefile
SIM      := verilator
TOP      := tb_mem_rd_top
FILELIST := list.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -Wno-fatal -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
